// File: compile.f
design/rv_pkg.sv
design/dec_exe_if.sv
design/exe_res_if.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core_top.sv
verification/rv_core_asserts.sv
verification/rv_core_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f compile.f --top-module rv_core_tb -o Vrv_core_tb
	./obj_dir/Vrv_core_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int          NUM_TESTS   = 6;
  localparam int          CYCLE_LIMIT = NUM_TESTS * 200;
  localparam int          MEM_WORDS   = 256;
  localparam logic [31:0] RAND_SEED   = 32'he5b6_fc30;
  localparam xlen_t       ECALL       = 32'h0000_0073;
  localparam xlen_t       FENCE       = 32'h0ff0_000f;
  localparam xlen_t       POISON      = 32'hdead_beef;
  localparam xlen_t       TAKEN_MARK  = 32'h7a4e_0001;
  localparam xlen_t       FALL_MARK   = 32'hf011_0002;
  localparam xlen_t       LOAD_BASE   = 32'h0000_0300;

  logic     clk;
  logic     rst;
  xlen_t    imem_addr;
  xlen_t    insn;
  xlen_t    dmem_addr;
  xlen_t    dmem_wdata;
  byte_en_t dmem_be;
  xlen_t    dmem_rdata;
  logic     halt;

  xlen_t    imem [MEM_WORDS];
  xlen_t    dmem [MEM_WORDS];
  xlen_t    prog [$];
  xlen_t    log_addr [$];
  xlen_t    log_data [$];
  byte_en_t log_be [$];
  xlen_t    exp_addr [$];
  xlen_t    exp_data [$];
  byte_en_t exp_be [$];

  string cur_test;
  int    cycles = 0;
  int    slot;
  int    errors = 0;
  int    test_errors;
  int    tests_passed = 0;
  int    tests_failed = 0;

  rv_core_top uut (
    .clk          (clk),
    .rst          (rst),
    .imem_addr_o  (imem_addr),
    .insn_i       (insn),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_be_o    (dmem_be),
    .dmem_rdata_i (dmem_rdata),
    .halt_o       (halt)
  );

  always #20 clk = ~clk;

  // both memories answer combinationally
  assign insn       = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  function automatic xlen_t lane_mask(byte_en_t be);
    xlen_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  // byte-enabled commit and store log
  always @(posedge clk) begin
    if (dmem_be != '0) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_be[b]) dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
      log_addr.push_back(dmem_addr);
      log_data.push_back(dmem_wdata & lane_mask(dmem_be));
      log_be.push_back(dmem_be);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the core never reached halt", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // instruction encoders
  function automatic xlen_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  funct3_t f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_OP};
  endfunction

  function automatic xlen_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                  reg_addr_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic xlen_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic xlen_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic xlen_t enc_u(logic [19:0] imm, reg_addr_t rd, opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic xlen_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // reference models from the RV32I definitions
  function automatic xlen_t alu_ref(alu_op_t op, xlen_t a, xlen_t b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return xlen_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
      ALU_SLTU: return xlen_t'(a < b);
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return ext[31:0];
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_ref(funct3_t f3, xlen_t a, xlen_t b);
    logic lt_s;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (f3)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return lt_s;
      BR_GE:   return !lt_s;
      BR_LTU:  return a < b;
      BR_GEU:  return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  function automatic xlen_t load_ref(funct3_t f3, xlen_t w, int off);
    xlen_t lane;
    lane = w >> (8 * off);
    case (f3)
      F3_BYTE:   return xlen_t'($signed(lane[7:0]));
      F3_BYTE_U: return xlen_t'(lane[7:0]);
      F3_HALF:   return xlen_t'($signed(lane[15:0]));
      F3_HALF_U: return xlen_t'(lane[15:0]);
      F3_WORD:   return w;
      default:   return '0;
    endcase
  endfunction

  function automatic xlen_t fill_word(int i);
    return (xlen_t'(i) * 32'h0104_0911) ^ 32'h5a5a_0000;
  endfunction

  function automatic xlen_t pc_now();
    return xlen_t'(prog.size() * 4);
  endfunction

  task automatic emit(xlen_t word);
    prog.push_back(word);
  endtask

  // lui then addi with the upper part rounded for the sign of the low 12 bits
  task automatic emit_li(reg_addr_t rd, xlen_t v);
    xlen_t hi;
    hi = v + 32'h800;
    emit(enc_u(hi[31:12], rd, OP_LUI));
    emit(enc_i(v[11:0], rd, 3'b000, rd, OP_OP_IMM));
  endtask

  task automatic expect_store(xlen_t addr, xlen_t data, byte_en_t be);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_be.push_back(be);
  endtask

  // sw of rd to the next result slot
  task automatic store_word(reg_addr_t rd, xlen_t expected);
    xlen_t addr;
    addr = 32'h100 + xlen_t'(4 * slot);
    emit(enc_s(addr[11:0], rd, 5'd0, F3_WORD));
    expect_store(addr, expected, 4'hf);
    slot++;
  endtask

  task automatic clear_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_be.delete();
    slot = 0;
  endtask

  task automatic check_word(string what, xlen_t expected, xlen_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_be(string what, byte_en_t expected, byte_en_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_flag(string what, logic expected, logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_log();
    check_word("store count", xlen_t'(exp_addr.size()), xlen_t'(log_addr.size()));
    for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
      check_word($sformatf("store %0d address", i), exp_addr[i], log_addr[i]);
      check_word($sformatf("store %0d data", i), exp_data[i], log_data[i]);
      check_be($sformatf("store %0d enables", i), exp_be[i], log_be[i]);
    end
  endtask

  // hold reset for 10 cycles while loading the program
  task automatic reset_core();
    @(negedge clk);
    rst = 1'b1;
    foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : ECALL;
    foreach (dmem[i]) dmem[i] <= fill_word(i);
    log_addr.delete();
    log_data.delete();
    log_be.delete();
    repeat (10) @(negedge clk);
  endtask

  task automatic run_to_halt();
    check_flag("halt in reset", 1'b0, halt);
    check_be("enables in reset", 4'h0, dmem_be);
    rst = 1'b0;
    @(negedge clk);
    while (!halt) @(negedge clk);
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    test_errors = 0;
    clear_program();
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: done, no errors", cur_test);
    end else begin
      tests_failed++;
      $display("%s: done, %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic test_alu();
    alu_op_t ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                          ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
    funct3_t f3s [10] = '{3'b000, 3'b000, 3'b001, 3'b010, 3'b011,
                          3'b100, 3'b101, 3'b101, 3'b110, 3'b111};
    xlen_t       a;
    xlen_t       b;
    logic [11:0] imm12;
    logic [6:0]  f7;
    begin_test("alu");
    a = $urandom();
    b = $urandom();
    emit_li(5'd1, a);
    emit_li(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      f7 = (ops[k] == ALU_SUB || ops[k] == ALU_SRA) ? F7_ALT : 7'b0;
      emit(enc_r(f7, 5'd2, 5'd1, f3s[k], 5'd3));
      store_word(5'd3, alu_ref(ops[k], a, b));
      // no immediate form of sub
      if (ops[k] != ALU_SUB) begin
        imm12 = 12'($urandom());
        if (f3s[k] == 3'b001 || f3s[k] == 3'b101) imm12[11:5] = f7;
        emit(enc_i(imm12, 5'd1, f3s[k], 5'd4, OP_OP_IMM));
        store_word(5'd4, alu_ref(ops[k], a, {{20{imm12[11]}}, imm12}));
      end
    end
    emit(ECALL);
    reset_core();
    run_to_halt();
    check_log();
    finish_test();
  endtask

  task automatic test_upper_jump();
    xlen_t p;
    begin_test("upper_jump");
    emit_li(5'd9, POISON);
    emit(enc_u(20'habcde, 5'd1, OP_LUI));
    p = pc_now();
    emit(enc_u(20'h12345, 5'd2, OP_AUIPC));
    store_word(5'd1, 32'habcd_e000);
    store_word(5'd2, p + 32'h1234_5000);
    p = pc_now();
    emit(enc_j(21'd8, 5'd3));
    emit(enc_s(12'h3f0, 5'd9, 5'd0, F3_WORD));
    store_word(5'd3, p + 32'd4);
    // jalr offset 13 lands on an odd address and bit 0 is dropped
    p = pc_now();
    emit(enc_u(20'h0, 5'd4, OP_AUIPC));
    emit(enc_i(12'd13, 5'd4, 3'b000, 5'd5, OP_JALR));
    emit(enc_s(12'h3f0, 5'd9, 5'd0, F3_WORD));
    store_word(5'd5, p + 32'd8);
    emit(ECALL);
    reset_core();
    run_to_halt();
    check_log();
    finish_test();
  endtask

  task automatic test_branches();
    funct3_t   f3s [12] = '{BR_EQ, BR_EQ, BR_NE, BR_NE, BR_LT, BR_LT,
                            BR_GE, BR_GE, BR_LTU, BR_LTU, BR_GEU, BR_GEU};
    reg_addr_t rs1s [12] = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2,
                             5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    reg_addr_t rs2s [12] = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd2, 5'd1,
                             5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    xlen_t     vals [4] = '{32'h0, 32'hffff_ffff, 32'h1, 32'h1};
    xlen_t     addr;
    logic      taken;
    begin_test("branches");
    emit_li(5'd1, vals[1]);
    emit_li(5'd2, vals[2]);
    emit_li(5'd3, vals[3]);
    emit_li(5'd10, TAKEN_MARK);
    emit_li(5'd11, FALL_MARK);
    for (int k = 0; k < 12; k++) begin
      addr = 32'h100 + xlen_t'(4 * k);
      emit(enc_b(13'd12, rs2s[k], rs1s[k], f3s[k]));
      emit(enc_s(addr[11:0], 5'd11, 5'd0, F3_WORD));
      emit(enc_j(21'd8, 5'd0));
      emit(enc_s(addr[11:0], 5'd10, 5'd0, F3_WORD));
      taken = branch_ref(f3s[k], vals[rs1s[k][1:0]], vals[rs2s[k][1:0]]);
      expect_store(addr, taken ? TAKEN_MARK : FALL_MARK, 4'hf);
    end
    emit(ECALL);
    reset_core();
    run_to_halt();
    check_log();
    finish_test();
  endtask

  task automatic test_stores();
    xlen_t v = 32'hc3a5_5a3c;
    begin_test("stores");
    // a store at pc 0 sits on the data port for the whole reset
    emit(enc_s(12'h210, 5'd0, 5'd0, F3_WORD));
    expect_store(32'h210, 32'h0, 4'hf);
    emit_li(5'd1, v);
    for (int off = 0; off < 4; off++) begin
      emit(enc_s(12'h200 + 12'(off), 5'd1, 5'd0, F3_BYTE));
      expect_store(32'h200, (v & 32'hff) << (8 * off), 4'b0001 << off);
    end
    for (int off = 0; off < 4; off += 2) begin
      emit(enc_s(12'h204 + 12'(off), 5'd1, 5'd0, F3_HALF));
      expect_store(32'h204, (v & 32'hffff) << (8 * off), 4'b0011 << off);
    end
    // odd halfword offsets write nothing
    emit(enc_s(12'h209, 5'd1, 5'd0, F3_HALF));
    emit(enc_s(12'h20b, 5'd1, 5'd0, F3_HALF));
    emit(enc_s(12'h20c, 5'd1, 5'd0, F3_WORD));
    expect_store(32'h20c, v, 4'hf);
    emit(ECALL);
    reset_core();
    run_to_halt();
    check_log();
    finish_test();
  endtask

  task automatic test_loads();
    xlen_t   w = 32'h7ef1_8035;
    funct3_t f3s [5] = '{F3_BYTE, F3_BYTE_U, F3_HALF, F3_HALF_U, F3_WORD};
    int      step;
    begin_test("loads");
    for (int k = 0; k < 5; k++) begin
      step = (f3s[k] == F3_WORD) ? 4 : (f3s[k] == F3_HALF || f3s[k] == F3_HALF_U) ? 2 : 1;
      for (int off = 0; off < 4; off += step) begin
        emit(enc_i(LOAD_BASE[11:0] + 12'(off), 5'd0, f3s[k], 5'd5, OP_LOAD));
        store_word(5'd5, load_ref(f3s[k], w, off));
      end
    end
    // x0 stays zero even as a load target
    emit(enc_i(LOAD_BASE[11:0], 5'd0, F3_WORD, 5'd0, OP_LOAD));
    store_word(5'd0, 32'h0);
    emit(ECALL);
    reset_core();
    dmem[LOAD_BASE[9:2]] <= w;
    run_to_halt();
    check_log();
    finish_test();
  endtask

  task automatic halt_run(xlen_t stop_insn);
    xlen_t stop_pc;
    clear_program();
    emit_li(5'd1, 32'h5555_aaaa);
    store_word(5'd1, 32'h5555_aaaa);
    stop_pc = pc_now();
    emit(stop_insn);
    emit(enc_s(12'h1f0, 5'd1, 5'd0, F3_WORD));
    emit(enc_s(12'h1f4, 5'd1, 5'd0, F3_WORD));
    reset_core();
    run_to_halt();
    repeat (20) begin
      check_flag("halt", 1'b1, halt);
      check_word("fetch address", stop_pc + 32'd4, imem_addr);
      @(negedge clk);
    end
    check_log();
  endtask

  task automatic test_halt();
    begin_test("halt");
    halt_run(ECALL);
    halt_run(FENCE);
    finish_test();
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    clk = 1'b0;
    rst = 1'b1;
    foreach (imem[i]) imem[i] = ECALL;
    foreach (dmem[i]) dmem[i] <= fill_word(i);
    test_alu();
    test_upper_jump();
    test_branches();
    test_stores();
    test_loads();
    test_halt();
    $display("summary: %0d tests clean, %0d tests with errors, %0d mismatches",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verification/rv_core_asserts.sv
`timescale 1ns/10ps

module rv_core_asserts (
  input logic             clk,
  input logic             rst,
  input rv_pkg::xlen_t    imem_addr_i,
  input rv_pkg::xlen_t    dmem_addr_i,
  input rv_pkg::byte_en_t dmem_be_i,
  input logic             halt_i
);

  // data port only ever sees word addresses
  assert property (@(posedge clk) dmem_addr_i[1:0] == 2'b00)
    else $error("data address %h is not word aligned", dmem_addr_i);

  assert property (@(posedge clk) (rst || halt_i) |-> dmem_be_i == '0)
    else $error("byte enables %b active during reset or halt", dmem_be_i);

  // fetch address frozen once halted
  assert property (@(posedge clk) disable iff (rst)
                   (halt_i && $past(halt_i)) |-> $stable(imem_addr_i))
    else $error("fetch address moved while halted");

endmodule

bind rv_core_top rv_core_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .imem_addr_i (imem_addr_o),
  .dmem_addr_i (dmem_addr_o),
  .dmem_be_i   (dmem_be_o),
  .halt_i      (halt_o)
);

// File: design/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::xlen_t    imem_addr_o,
  input  rv_pkg::xlen_t    insn_i,
  output rv_pkg::xlen_t    dmem_addr_o,
  output rv_pkg::xlen_t    dmem_wdata_o,
  output rv_pkg::byte_en_t dmem_be_o,
  input  rv_pkg::xlen_t    dmem_rdata_i,
  output logic             halt_o
);
  import rv_pkg::*;

  xlen_t     pc;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_val;
  xlen_t     rs2_val;
  logic      rf_we;
  reg_addr_t rf_waddr;
  xlen_t     rf_wdata;

  dec_exe_if dx ();
  exe_res_if xr ();

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .raddr1_i (rs1_addr),
    .raddr2_i (rs2_addr),
    .rdata1_o (rs1_val),
    .rdata2_o (rs2_val)
  );

  rv_decode u_decode (
    .insn_i     (insn_i),
    .pc_i       (pc),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_val_i  (rs1_val),
    .rs2_val_i  (rs2_val),
    .dx         (dx.decode)
  );

  rv_execute u_execute (
    .dx (dx.execute),
    .xr (xr.execute)
  );

  rv_result u_result (
    .clk          (clk),
    .rst          (rst),
    .xr           (xr.result),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_be_o    (dmem_be_o),
    .pc_o         (pc),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata),
    .halt_o       (halt_o)
  );

  // instruction fetch address is the current pc
  assign imem_addr_o = pc;

endmodule

// File: design/rv_result.sv
`timescale 1ns/10ps

module rv_result (
  input  logic              clk,
  input  logic              rst,
  exe_res_if.result         xr,
  input  rv_pkg::xlen_t     dmem_rdata_i,
  output rv_pkg::xlen_t     dmem_addr_o,
  output rv_pkg::xlen_t     dmem_wdata_o,
  output rv_pkg::byte_en_t  dmem_be_o,
  output rv_pkg::xlen_t     pc_o,
  output logic              rf_we_o,
  output rv_pkg::reg_addr_t rf_waddr_o,
  output rv_pkg::xlen_t     rf_wdata_o,
  output logic              halt_o
);
  import rv_pkg::*;

  xlen_t      pc_q;
  xlen_t      pc_plus;
  xlen_t      next_pc;
  logic       halt_q;
  logic       redirect;
  logic [1:0] byte_off;
  xlen_t      lane;
  xlen_t      load_val;
  byte_en_t   st_be;
  logic       store_en;
  logic       writes_rd;

  assign pc_plus  = pc_q + xlen_t'(PC_STEP);
  assign redirect = (xr.cls == CLS_JAL) || (xr.cls == CLS_JALR) || xr.taken;
  assign next_pc  = redirect ? xr.target : pc_plus;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q   <= '0;
      halt_q <= 1'b0;
    end else if (!halt_q) begin
      // the halting instruction still advances pc, then it freezes
      pc_q <= next_pc;
      if (xr.cls == CLS_HALT) halt_q <= 1'b1;
    end
  end

  assign byte_off    = xr.mem_addr[1:0];
  assign dmem_addr_o = {xr.mem_addr[XLEN-1:2], 2'b00};

  // store data is replicated over every lane and the enables pick the bytes
  always_comb begin
    dmem_wdata_o = xr.store_val;
    st_be        = '0;
    case (xr.funct3)
      F3_BYTE: begin
        dmem_wdata_o = {4{xr.store_val[7:0]}};
        st_be        = byte_en_t'(4'b0001 << byte_off);
      end
      F3_HALF: begin
        dmem_wdata_o = {2{xr.store_val[15:0]}};
        if (!byte_off[0]) begin
          st_be = byte_off[1] ? 4'b1100 : 4'b0011;
        end
      end
      F3_WORD: begin
        if (byte_off == 2'b00) st_be = 4'b1111;
      end
      default: st_be = '0;
    endcase
  end

  // no memory writes while in reset or halted
  assign store_en  = (xr.cls == CLS_STORE) && !halt_q && !rst;
  assign dmem_be_o = store_en ? st_be : '0;

  // shift the addressed byte lane down to bit 0
  assign lane = dmem_rdata_i >> {byte_off, 3'b000};

  // misaligned half and word loads give zero
  always_comb begin
    case (xr.funct3)
      F3_BYTE:   load_val = {{24{lane[7]}}, lane[7:0]};
      F3_BYTE_U: load_val = {24'b0, lane[7:0]};
      F3_HALF:   load_val = byte_off[0] ? '0 : {{16{lane[15]}}, lane[15:0]};
      F3_HALF_U: load_val = byte_off[0] ? '0 : {16'b0, lane[15:0]};
      F3_WORD:   load_val = (byte_off == 2'b00) ? dmem_rdata_i : '0;
      default:   load_val = '0;
    endcase
  end

  always_comb begin
    case (xr.cls)
      CLS_ALU, CLS_LOAD, CLS_JAL, CLS_JALR, CLS_LUI, CLS_AUIPC: writes_rd = 1'b1;
      default: writes_rd = 1'b0;
    endcase
  end

  always_comb begin
    case (xr.cls)
      CLS_LOAD:          rf_wdata_o = load_val;
      CLS_JAL, CLS_JALR: rf_wdata_o = pc_plus;
      default:           rf_wdata_o = xr.alu_val;
    endcase
  end

  assign rf_we_o    = writes_rd && !halt_q;
  assign rf_waddr_o = xr.rd;
  assign pc_o       = pc_q;
  assign halt_o     = halt_q;

endmodule

// File: design/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  dec_exe_if.execute dx,
  exe_res_if.execute xr
);
  import rv_pkg::*;

  xlen_t      op_b;
  logic [4:0] shamt;
  xlen_t      alu_res;
  xlen_t      addr_sum;
  xlen_t      pc_rel;
  logic       cond;

  assign op_b  = dx.use_imm ? dx.imm : dx.rs2_val;
  // immediate shifts take the amount from imm[4:0]
  assign shamt = op_b[4:0];

  always_comb begin
    case (dx.alu_op)
      ALU_ADD:  alu_res = dx.rs1_val + op_b;
      ALU_SUB:  alu_res = dx.rs1_val - op_b;
      ALU_SLL:  alu_res = dx.rs1_val << shamt;
      ALU_SLT:  alu_res = xlen_t'($signed(dx.rs1_val) < $signed(op_b));
      ALU_SLTU: alu_res = xlen_t'(dx.rs1_val < op_b);
      ALU_XOR:  alu_res = dx.rs1_val ^ op_b;
      ALU_SRL:  alu_res = dx.rs1_val >> shamt;
      ALU_SRA:  alu_res = xlen_t'($signed(dx.rs1_val) >>> shamt);
      ALU_OR:   alu_res = dx.rs1_val | op_b;
      ALU_AND:  alu_res = dx.rs1_val & op_b;
      default:  alu_res = dx.rs1_val + op_b;
    endcase
  end

  // branch compare always on rs1 and rs2
  always_comb begin
    case (dx.funct3)
      BR_EQ:   cond = (dx.rs1_val == dx.rs2_val);
      BR_NE:   cond = (dx.rs1_val != dx.rs2_val);
      BR_LT:   cond = ($signed(dx.rs1_val) < $signed(dx.rs2_val));
      BR_GE:   cond = ($signed(dx.rs1_val) >= $signed(dx.rs2_val));
      BR_LTU:  cond = (dx.rs1_val < dx.rs2_val);
      BR_GEU:  cond = (dx.rs1_val >= dx.rs2_val);
      default: cond = 1'b0;
    endcase
  end

  // rs1 + imm serves loads, stores and jalr
  assign addr_sum = dx.rs1_val + dx.imm;
  assign pc_rel   = dx.pc + dx.imm;

  always_comb begin
    case (dx.cls)
      CLS_LUI:   xr.alu_val = dx.imm;
      CLS_AUIPC: xr.alu_val = pc_rel;
      default:   xr.alu_val = alu_res;
    endcase
  end

  assign xr.target = (dx.cls == CLS_JALR) ? {addr_sum[XLEN-1:1], 1'b0} : pc_rel;
  assign xr.taken  = (dx.cls == CLS_BRANCH) && cond;

  assign xr.mem_addr  = addr_sum;
  assign xr.store_val = dx.rs2_val;
  assign xr.cls       = dx.cls;
  assign xr.funct3    = dx.funct3;
  assign xr.rd        = dx.rd;

endmodule

// File: design/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
  input  rv_pkg::xlen_t     insn_i,
  input  rv_pkg::xlen_t     pc_i,
  output rv_pkg::reg_addr_t rs1_addr_o,
  output rv_pkg::reg_addr_t rs2_addr_o,
  input  rv_pkg::xlen_t     rs1_val_i,
  input  rv_pkg::xlen_t     rs2_val_i,
  dec_exe_if.decode         dx
);
  import rv_pkg::*;

  opcode_t    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_j;
  xlen_t      imm_u;
  logic       f7_ok;

  assign opcode = opcode_t'(insn_i[6:0]);
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  assign rs1_addr_o = insn_i[19:15];
  assign rs2_addr_o = insn_i[24:20];

  // sign-extended immediates for each format
  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_u = {insn_i[31:12], 12'b0};

  // funct7 only matters for register ops and shifts;
  // the alternate form exists for sub, sra and srai only
  always_comb begin
    f7_ok = 1'b1;
    if (opcode == OP_OP || funct3 == 3'b001 || funct3 == 3'b101) begin
      f7_ok = (funct7 == 7'b0) ||
              (funct7 == F7_ALT && (funct3 == 3'b101 ||
                                    (funct3 == 3'b000 && opcode == OP_OP)));
    end
  end

  always_comb begin
    case (funct3)
      3'b000:  dx.alu_op = (opcode == OP_OP && insn_i[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  dx.alu_op = ALU_SLL;
      3'b010:  dx.alu_op = ALU_SLT;
      3'b011:  dx.alu_op = ALU_SLTU;
      3'b100:  dx.alu_op = ALU_XOR;
      3'b101:  dx.alu_op = insn_i[30] ? ALU_SRA : ALU_SRL;
      3'b110:  dx.alu_op = ALU_OR;
      default: dx.alu_op = ALU_AND;
    endcase
  end

  // classify the opcode and pick its immediate
  always_comb begin
    dx.cls = CLS_NOP;
    dx.imm = imm_i;
    case (opcode)
      OP_LUI: begin
        dx.cls = CLS_LUI;
        dx.imm = imm_u;
      end
      OP_AUIPC: begin
        dx.cls = CLS_AUIPC;
        dx.imm = imm_u;
      end
      OP_JAL: begin
        dx.cls = CLS_JAL;
        dx.imm = imm_j;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) dx.cls = CLS_JALR;
      end
      OP_BRANCH: begin
        dx.imm = imm_b;
        if (funct3 inside {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU}) dx.cls = CLS_BRANCH;
      end
      OP_LOAD: begin
        if (funct3 inside {F3_BYTE, F3_HALF, F3_WORD, F3_BYTE_U, F3_HALF_U}) dx.cls = CLS_LOAD;
      end
      OP_STORE: begin
        dx.imm = imm_s;
        if (funct3 inside {F3_BYTE, F3_HALF, F3_WORD}) dx.cls = CLS_STORE;
      end
      OP_OP_IMM, OP_OP: begin
        if (f7_ok) dx.cls = CLS_ALU;
      end
      // ecall and fence stop the core while ebreak and csr ops fall through as nops
      OP_SYSTEM: begin
        if (insn_i[31:7] == '0) dx.cls = CLS_HALT;
      end
      OP_MISC_MEM: begin
        if (funct3 == 3'b000) dx.cls = CLS_HALT;
      end
      default: dx.cls = CLS_NOP;
    endcase
  end

  assign dx.use_imm = (opcode == OP_OP_IMM);
  assign dx.funct3  = funct3;
  assign dx.rs1_val = rs1_val_i;
  assign dx.rs2_val = rs2_val_i;
  assign dx.rd      = insn_i[11:7];
  assign dx.pc      = pc_i;

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we_i,
  input  rv_pkg::reg_addr_t waddr_i,
  input  rv_pkg::xlen_t     wdata_i,
  input  rv_pkg::reg_addr_t raddr1_i,
  input  rv_pkg::reg_addr_t raddr2_i,
  output rv_pkg::xlen_t     rdata1_o,
  output rv_pkg::xlen_t     rdata2_o
);
  import rv_pkg::*;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      // x0 is never written
      regs[waddr_i] <= wdata_i;
    end
  end

  // combinational reads with x0 read as zero
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: design/exe_res_if.sv
`timescale 1ns/10ps

interface exe_res_if;
  import rv_pkg::*;

  insn_class_t cls;
  funct3_t     funct3;
  reg_addr_t   rd;
  xlen_t       alu_val;
  // unaligned byte address of a load or store
  xlen_t       mem_addr;
  xlen_t       store_val;
  logic        taken;
  xlen_t       target;

  modport execute (
    output cls, funct3, rd, alu_val, mem_addr, store_val, taken, target
  );

  modport result (
    input cls, funct3, rd, alu_val, mem_addr, store_val, taken, target
  );

endinterface

// File: design/dec_exe_if.sv
`timescale 1ns/10ps

interface dec_exe_if;
  import rv_pkg::*;

  insn_class_t cls;
  alu_op_t     alu_op;
  funct3_t     funct3;
  // second ALU operand comes from imm instead of rs2
  logic        use_imm;
  xlen_t       rs1_val;
  xlen_t       rs2_val;
  xlen_t       imm;
  reg_addr_t   rd;
  xlen_t       pc;

  modport decode (
    output cls, alu_op, funct3, use_imm,
    output rs1_val, rs2_val, imm, rd, pc
  );

  modport execute (
    input cls, alu_op, funct3, use_imm,
    input rs1_val, rs2_val, imm, rd, pc
  );

endinterface

// File: design/rv_pkg.sv
package rv_pkg;

  // machine word and register file geometry
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int PC_STEP  = 4;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      byte_en_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_STORE    = 7'b0100011,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_MISC_MEM = 7'b0001111,
    OP_JAL      = 7'b1101111,
    OP_OP_IMM   = 7'b0010011,
    OP_OP       = 7'b0110011,
    OP_SYSTEM   = 7'b1110011,
    OP_AUIPC    = 7'b0010111,
    OP_LUI      = 7'b0110111
  } opcode_t;

  typedef logic [2:0] funct3_t;

  // memory access sizes
  localparam funct3_t F3_BYTE   = 3'b000;
  localparam funct3_t F3_HALF   = 3'b001;
  localparam funct3_t F3_WORD   = 3'b010;
  localparam funct3_t F3_BYTE_U = 3'b100;
  localparam funct3_t F3_HALF_U = 3'b101;

  // branch conditions
  localparam funct3_t BR_EQ  = 3'b000;
  localparam funct3_t BR_NE  = 3'b001;
  localparam funct3_t BR_LT  = 3'b100;
  localparam funct3_t BR_GE  = 3'b101;
  localparam funct3_t BR_LTU = 3'b110;
  localparam funct3_t BR_GEU = 3'b111;

  // funct7 for sub and arithmetic right shift
  localparam logic [6:0] F7_ALT = 7'b0100000;

  typedef enum logic [3:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_LUI,
    CLS_AUIPC,
    CLS_HALT,
    CLS_NOP
  } insn_class_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

endpackage
